// File: source/xt_bus_pkg.sv
//##########################################################################
// hb bus constants: widths, address map, register offsets and the
// release code that hands instruction fetch over to user memory
//##########################################################################
package xt_bus_pkg;

  // bus widths
  localparam int hb_addr_w = 8;
  localparam int hb_data_w = 32;

  // instruction side, 64 words
  localparam int pc_w = 6;

  // identification string rom
  localparam int str_addr_w = 6;

  // address bits 7..6 select the slave
  localparam logic [1:0] slot_boot = 2'd0;
  localparam logic [1:0] slot_imem = 2'd1;

  // bootloader register offsets, address bits 1..0
  // offset 0 writes the debug register and reads the status
  localparam logic [1:0] reg_debug = 2'd0;
  localparam logic [1:0] reg_str_addr = 2'd1;
  localparam logic [1:0] reg_str_data = 2'd2;

  // debug register value that releases the core to user code
  localparam logic [7:0] boot_release = 8'hF0;

endpackage

// File: source/str_rom.sv
//##########################################################################
// identification string rom, 64 x 8, combinational lookup
//##########################################################################
module str_rom (
  input  logic [xt_bus_pkg::str_addr_w-1:0] addr,
  output logic [7:0]                        data
);

  // "HB BOOT V1", zero padded
  always_comb begin
    case (addr)
      6'd0: begin
        data = 8'h48;
      end
      6'd1: begin
        data = 8'h42;
      end
      6'd2: begin
        data = 8'h20;
      end
      6'd3: begin
        data = 8'h42;
      end
      6'd4: begin
        data = 8'h4F;
      end
      6'd5: begin
        data = 8'h4F;
      end
      6'd6: begin
        data = 8'h54;
      end
      6'd7: begin
        data = 8'h20;
      end
      6'd8: begin
        data = 8'h56;
      end
      6'd9: begin
        data = 8'h31;
      end
      default: begin
        data = 8'h00;
      end
    endcase
  end

endmodule

// File: source/boot_rom.sv
//##########################################################################
// boot program rom, 64 words indexed by pc; polls the download_mode
// status and parks the core in a self loop
//##########################################################################
module boot_rom (
  input  logic [xt_bus_pkg::pc_w-1:0]      pc,
  output logic [xt_bus_pkg::hb_data_w-1:0] instruction
);

  always_comb begin
    case (pc)
      // x1 = bootloader base, x2 = poll counter
      6'd0:  instruction = 32'h00000093;
      6'd1:  instruction = 32'h00000113;
      // wait for download_mode high
      6'd2:  instruction = 32'h0000A183;
      6'd3:  instruction = 32'h0011F193;
      6'd4:  instruction = 32'hFE018CE3;
      6'd5:  instruction = 32'h00110113;
      // then wait for it to drop again
      6'd6:  instruction = 32'h0000A183;
      6'd7:  instruction = 32'h0011F193;
      6'd8:  instruction = 32'hFE019CE3;
      // clear scratch registers, x4 = user stack top
      6'd9:  instruction = 32'h04000213;
      6'd10: instruction = 32'h00000293;
      6'd11: instruction = 32'h00000313;
      6'd12: instruction = 32'h00000393;
      6'd13: instruction = 32'h00000013;
      6'd14: instruction = 32'h00000013;
      // jal x0, 0
      // core spins here until the release code switches fetch
      6'd15: instruction = 32'h0000006F;
      default: begin
        instruction = 32'h00000013;
      end
    endcase
  end

endmodule

// File: source/user_imem.sv
//##########################################################################
// user instruction memory, 64 words; bus write and registered bus read,
// plus a combinational fetch port for the core
//##########################################################################
module user_imem (
  input  logic                              hb_clk,
  input  logic                              wen,
  input  logic [xt_bus_pkg::hb_addr_w-1:0]  waddr,
  input  logic [xt_bus_pkg::hb_data_w-1:0]  wdata,
  input  logic                              ren,
  input  logic [xt_bus_pkg::hb_addr_w-1:0]  raddr,
  output logic [xt_bus_pkg::hb_data_w-1:0]  rdata,
  input  logic [xt_bus_pkg::pc_w-1:0]       pc,
  output logic [xt_bus_pkg::hb_data_w-1:0]  instruction
);

  logic [xt_bus_pkg::hb_data_w-1:0] mem [2**xt_bus_pkg::pc_w];

  // word index from the low address bits
  logic [xt_bus_pkg::pc_w-1:0] widx;
  logic [xt_bus_pkg::pc_w-1:0] ridx;

  assign widx = waddr[xt_bus_pkg::pc_w-1:0];
  assign ridx = raddr[xt_bus_pkg::pc_w-1:0];

  // host download
  always_ff @(posedge hb_clk) begin
    if (wen) begin
      mem[widx] <= wdata;
    end
  end

  // readback, held until the next read
  always_ff @(posedge hb_clk) begin
    if (ren) begin
      rdata <= mem[ridx];
    end
  end

  // fetch port
  assign instruction = mem[pc];

endmodule

// File: source/hb_decoder.sv
//##########################################################################
// hb bus decoder: per-slave strobes from the top address bits and
// read data return from the slot that was last read
//##########################################################################
module hb_decoder (
  input  logic                             hb_clk,
  input  logic                             rst_sync,
  input  logic [xt_bus_pkg::hb_addr_w-1:0] waddr,
  input  logic [xt_bus_pkg::hb_addr_w-1:0] raddr,
  input  logic                             wen,
  input  logic                             ren,
  output logic                             boot_wen,
  output logic                             boot_ren,
  output logic                             imem_wen,
  output logic                             imem_ren,
  input  logic [xt_bus_pkg::hb_data_w-1:0] boot_rdata,
  input  logic [xt_bus_pkg::hb_data_w-1:0] imem_rdata,
  output logic [xt_bus_pkg::hb_data_w-1:0] rdata
);

  logic [1:0] wslot;
  logic [1:0] rslot;
  logic [1:0] rd_slot;

  assign wslot = waddr[xt_bus_pkg::hb_addr_w-1 -: 2];
  assign rslot = raddr[xt_bus_pkg::hb_addr_w-1 -: 2];

  // slots 2 and 3 are unmapped, no strobe
  assign boot_wen = wen && (wslot == xt_bus_pkg::slot_boot);
  assign imem_wen = wen && (wslot == xt_bus_pkg::slot_imem);
  assign boot_ren = ren && (rslot == xt_bus_pkg::slot_boot);
  assign imem_ren = ren && (rslot == xt_bus_pkg::slot_imem);

  // slot of the last read, same edge as the slave registers its data
  always_ff @(posedge hb_clk) begin
    if (rst_sync) begin
      rd_slot <= xt_bus_pkg::slot_boot;
    end else if (ren) begin
      rd_slot <= rslot;
    end
  end

  // unmapped reads fall through to the bootloader's held data
  always_comb begin
    if (rd_slot == xt_bus_pkg::slot_imem) begin
      rdata = imem_rdata;
    end else begin
      rdata = boot_rdata;
    end
  end

endmodule

// File: source/harvard_bootloader.sv
//##########################################################################
// bootloader control: debug/mode register, status read, auto-increment
// window into the id string rom and the instruction source select
//##########################################################################
module harvard_bootloader (
  input  logic                             hb_clk,
  input  logic                             rst_sync,
  input  logic                             wen,
  input  logic                             ren,
  input  logic [xt_bus_pkg::hb_addr_w-1:0] waddr,
  input  logic [xt_bus_pkg::hb_addr_w-1:0] raddr,
  input  logic [xt_bus_pkg::hb_data_w-1:0] wdata,
  output logic [xt_bus_pkg::hb_data_w-1:0] rdata,
  input  logic                             download_mode,
  input  logic [xt_bus_pkg::hb_data_w-1:0] bootloader_instruction,
  input  logic [xt_bus_pkg::hb_data_w-1:0] user_instruction,
  output logic [xt_bus_pkg::hb_data_w-1:0] instruction
);

  logic w_debug;
  logic w_str_addr;
  logic r_status;
  logic r_str_data;

  assign w_debug    = waddr[1:0] == xt_bus_pkg::reg_debug;
  assign w_str_addr = waddr[1:0] == xt_bus_pkg::reg_str_addr;
  assign r_status   = raddr[1:0] == xt_bus_pkg::reg_debug;
  assign r_str_data = raddr[1:0] == xt_bus_pkg::reg_str_data;

  // string pointer, advances on each data read
  logic [xt_bus_pkg::str_addr_w-1:0] str_ptr;
  logic [xt_bus_pkg::str_addr_w-1:0] str_ptr_byp;
  logic [7:0]                        str_byte;

  // new pointer goes to the rom in the write cycle
  always_comb begin
    if (wen && w_str_addr) begin
      str_ptr_byp = wdata[xt_bus_pkg::str_addr_w-1:0];
    end else begin
      str_ptr_byp = str_ptr;
    end
  end

  always_ff @(posedge hb_clk) begin
    if (wen && w_str_addr) begin
      str_ptr <= wdata[xt_bus_pkg::str_addr_w-1:0];
    end else if (ren && r_str_data) begin
      str_ptr <= str_ptr + 1'b1;
    end
  end

  str_rom str_rom_i (
    .addr (str_ptr_byp),
    .data (str_byte)
  );

  // debug register and run mode
  logic [7:0] debug_reg;
  logic       user_mode;

  always_ff @(posedge hb_clk) begin
    if (rst_sync) begin
      debug_reg <= 8'h00;
    end else if (wen && w_debug) begin
      debug_reg <= wdata[7:0];
    end
  end

  // one cycle behind the debug write, sticky until reset
  always_ff @(posedge hb_clk) begin
    if (rst_sync) begin
      user_mode <= 1'b0;
    end else if (debug_reg == xt_bus_pkg::boot_release) begin
      user_mode <= 1'b1;
    end
  end

  assign instruction = user_mode ? user_instruction : bootloader_instruction;

  // register read
  always_ff @(posedge hb_clk) begin
    if (ren) begin
      if (r_status) begin
        rdata <= {{(xt_bus_pkg::hb_data_w-1){1'b0}}, download_mode};
      end else begin
        rdata <= {{(xt_bus_pkg::hb_data_w-8){1'b0}}, str_byte};
      end
    end
  end

endmodule

// File: source/hb_soc_top.sv
//##########################################################################
// instruction-side boot subsystem: hb decoder, bootloader, boot rom
// and user instruction memory
//##########################################################################
module hb_soc_top (
  input  logic                             hb_clk,
  input  logic                             rst_sync,
  input  logic [xt_bus_pkg::hb_addr_w-1:0] waddr,
  input  logic [xt_bus_pkg::hb_data_w-1:0] wdata,
  input  logic                             wen,
  input  logic [xt_bus_pkg::hb_addr_w-1:0] raddr,
  input  logic                             ren,
  output logic [xt_bus_pkg::hb_data_w-1:0] rdata,
  input  logic [xt_bus_pkg::pc_w-1:0]      pc,
  output logic [xt_bus_pkg::hb_data_w-1:0] instruction,
  input  logic                             download_mode
);

  // per-slave strobes
  logic boot_wen;
  logic boot_ren;
  logic imem_wen;
  logic imem_ren;

  // registered slave read data
  logic [xt_bus_pkg::hb_data_w-1:0] boot_rdata;
  logic [xt_bus_pkg::hb_data_w-1:0] imem_rdata;

  // fetch candidates
  logic [xt_bus_pkg::hb_data_w-1:0] boot_instr;
  logic [xt_bus_pkg::hb_data_w-1:0] user_instr;

  hb_decoder hb_decoder_i (
    .hb_clk     (hb_clk),
    .rst_sync   (rst_sync),
    .waddr      (waddr),
    .raddr      (raddr),
    .wen        (wen),
    .ren        (ren),
    .boot_wen   (boot_wen),
    .boot_ren   (boot_ren),
    .imem_wen   (imem_wen),
    .imem_ren   (imem_ren),
    .boot_rdata (boot_rdata),
    .imem_rdata (imem_rdata),
    .rdata      (rdata)
  );

  harvard_bootloader harvard_bootloader_i (
    .hb_clk                 (hb_clk),
    .rst_sync               (rst_sync),
    .wen                    (boot_wen),
    .ren                    (boot_ren),
    .waddr                  (waddr),
    .raddr                  (raddr),
    .wdata                  (wdata),
    .rdata                  (boot_rdata),
    .download_mode          (download_mode),
    .bootloader_instruction (boot_instr),
    .user_instruction       (user_instr),
    .instruction            (instruction)
  );

  boot_rom boot_rom_i (
    .pc          (pc),
    .instruction (boot_instr)
  );

  user_imem user_imem_i (
    .hb_clk      (hb_clk),
    .wen         (imem_wen),
    .waddr       (waddr),
    .wdata       (wdata),
    .ren         (imem_ren),
    .raddr       (raddr),
    .rdata       (imem_rdata),
    .pc          (pc),
    .instruction (user_instr)
  );

endmodule

// File: tests/tb_hb_soc_top.sv
//##########################################################################
// testbench for the boot subsystem: table of bus and fetch operations
// checked against reference copies of the boot rom and id string
//##########################################################################
module tb_hb_soc_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [1:0] op_write = 2'd0;
  localparam logic [1:0] op_read  = 2'd1;
  localparam logic [1:0] op_fetch = 2'd2;
  localparam logic [1:0] op_reset = 2'd3;

  localparam int tbl_max = 512;

  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  addr;
    logic [31:0] data;
    logic        dm;
    logic [31:0] exp_val;
  } op_t;

  logic        hb_clk;
  logic        rst_sync;
  logic [7:0]  waddr;
  logic [31:0] wdata;
  logic        wen;
  logic [7:0]  raddr;
  logic        ren;
  logic [31:0] rdata;
  logic [5:0]  pc;
  logic [31:0] instruction;
  logic        download_mode;

  op_t         tbl [tbl_max];
  int          tbl_len;
  logic [31:0] boot_tbl [16];
  logic [31:0] user_words [64];
  string       id_str;

  int check_cnt;
  int err_cnt;
  int timeout_cnt;
  int cycle_cnt;
  int cycle_limit;

  hb_soc_top hb_soc_top_i (
    .hb_clk        (hb_clk),
    .rst_sync      (rst_sync),
    .waddr         (waddr),
    .wdata         (wdata),
    .wen           (wen),
    .raddr         (raddr),
    .ren           (ren),
    .rdata         (rdata),
    .pc            (pc),
    .instruction   (instruction),
    .download_mode (download_mode)
  );

  always #2 hb_clk = ~hb_clk;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] slot_addr(input logic [1:0] slot, input logic [5:0] off);
    return {slot, off};
  endfunction

  // words past the program are no-ops
  function automatic logic [31:0] boot_word(input int p);
    if (p < 16) begin
      return boot_tbl[p];
    end
    return 32'h00000013;
  endfunction

  function automatic logic [31:0] id_byte(input int idx);
    if (idx < id_str.len()) begin
      return {24'h0, id_str[idx]};
    end
    return 32'h0;
  endfunction

  task automatic load_references();
    id_str = "HB BOOT V1";
    boot_tbl[0]  = 32'h00000093;
    boot_tbl[1]  = 32'h00000113;
    boot_tbl[2]  = 32'h0000A183;
    boot_tbl[3]  = 32'h0011F193;
    boot_tbl[4]  = 32'hFE018CE3;
    boot_tbl[5]  = 32'h00110113;
    boot_tbl[6]  = 32'h0000A183;
    boot_tbl[7]  = 32'h0011F193;
    boot_tbl[8]  = 32'hFE019CE3;
    boot_tbl[9]  = 32'h04000213;
    boot_tbl[10] = 32'h00000293;
    boot_tbl[11] = 32'h00000313;
    boot_tbl[12] = 32'h00000393;
    boot_tbl[13] = 32'h00000013;
    boot_tbl[14] = 32'h00000013;
    boot_tbl[15] = 32'h0000006F;
  endtask

  task automatic add_op(input logic [1:0] kind, input logic [7:0] addr,
                        input logic [31:0] data, input logic dm,
                        input logic [31:0] exp_val);
    tbl[tbl_len].kind    = kind;
    tbl[tbl_len].addr    = addr;
    tbl[tbl_len].data    = data;
    tbl[tbl_len].dm      = dm;
    tbl[tbl_len].exp_val = exp_val;
    tbl_len++;
  endtask

  task automatic build_table();
    int          i;
    logic [31:0] state;
    logic [7:0]  a_status;
    logic [7:0]  a_ptr;
    logic [7:0]  a_str;
    a_status = slot_addr(xt_bus_pkg::slot_boot, {4'd0, xt_bus_pkg::reg_debug});
    a_ptr    = slot_addr(xt_bus_pkg::slot_boot, {4'd0, xt_bus_pkg::reg_str_addr});
    a_str    = slot_addr(xt_bus_pkg::slot_boot, {4'd0, xt_bus_pkg::reg_str_data});
    tbl_len  = 0;
    // fetch from boot rom after reset
    for (i = 0; i <= 20; i++) begin
      add_op(op_fetch, i, 0, 1'b0, boot_word(i));
    end
    // status, pin low then high
    add_op(op_read, a_status, 0, 1'b0, 32'h0);
    add_op(op_read, a_status, 0, 1'b1, 32'h1);
    // id string walk
    add_op(op_write, a_ptr, 32'd0, 1'b0, 0);
    for (i = 0; i < 11; i++) begin
      add_op(op_read, a_str, 0, 1'b0, id_byte(i));
    end
    add_op(op_write, a_ptr, 32'd3, 1'b0, 0);
    add_op(op_read, a_str, 0, 1'b0, id_byte(3));
    add_op(op_read, a_str, 0, 1'b0, id_byte(4));
    // download while still fetching from boot rom
    state = 32'd14;
    for (i = 0; i < 64; i++) begin
      state = xorshift32(state);
      user_words[i] = state;
      add_op(op_write, slot_addr(xt_bus_pkg::slot_imem, i), state, 1'b1, 0);
      add_op(op_fetch, i, 0, 1'b1, boot_word(i));
    end
    for (i = 0; i < 64; i++) begin
      add_op(op_read, slot_addr(xt_bus_pkg::slot_imem, i), 0, 1'b0, user_words[i]);
    end
    // wrong code keeps boot fetch
    add_op(op_write, a_status, 32'h55, 1'b0, 0);
    add_op(op_fetch, 0, 0, 1'b0, boot_word(0));
    add_op(op_fetch, 5, 0, 1'b0, boot_word(5));
    add_op(op_fetch, 15, 0, 1'b0, boot_word(15));
    // release: first cycle after the write still boot
    add_op(op_write, a_status, {24'h0, xt_bus_pkg::boot_release}, 1'b0, 0);
    add_op(op_fetch, 7, 0, 1'b0, boot_word(7));
    for (i = 0; i < 64; i++) begin
      add_op(op_fetch, i, 0, 1'b0, user_words[i]);
    end
    // reset goes back to boot, memory survives
    add_op(op_reset, 0, 0, 1'b0, 0);
    for (i = 0; i <= 15; i++) begin
      add_op(op_fetch, i, 0, 1'b0, boot_word(i));
    end
    add_op(op_fetch, 40, 0, 1'b0, boot_word(40));
    for (i = 0; i < 64; i++) begin
      add_op(op_read, slot_addr(xt_bus_pkg::slot_imem, i), 0, 1'b0, user_words[i]);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_cnt++;
    if (actual !== expected) begin
      err_cnt++;
      $display("ERR t=%0t %s actual=%h expected=%h", $time, name, actual, expected);
    end
  endtask

  // entered and left 0.5 ns after a rising edge
  task automatic run_op(input op_t op);
    download_mode = op.dm;
    case (op.kind)
      op_write: begin
        waddr = op.addr;
        wdata = op.data;
        wen   = 1'b1;
        @(posedge hb_clk);
        #0.5;
        wen = 1'b0;
      end
      op_read: begin
        raddr = op.addr;
        ren   = 1'b1;
        @(posedge hb_clk);
        #0.5;
        ren = 1'b0;
        check_value("rdata", rdata, op.exp_val);
      end
      op_fetch: begin
        pc = op.addr[5:0];
        #1;
        check_value("instruction", instruction, op.exp_val);
        @(posedge hb_clk);
        #0.5;
      end
      default: begin
        rst_sync = 1'b1;
        repeat (2) @(posedge hb_clk);
        #0.5;
        rst_sync = 1'b0;
      end
    endcase
  endtask

  task automatic finish_run();
    $display("checks=%0d errors=%0d timeouts=%0d", check_cnt, err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  endtask

  always @(posedge hb_clk) begin
    cycle_cnt++;
    if (cycle_cnt >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_cnt);
      timeout_cnt++;
      finish_run();
    end
  end

  initial begin
    hb_clk        = 1'b0;
    rst_sync      = 1'b1;
    waddr         = '0;
    wdata         = '0;
    wen           = 1'b0;
    raddr         = '0;
    ren           = 1'b0;
    pc            = '0;
    download_mode = 1'b0;
    check_cnt     = 0;
    err_cnt       = 0;
    timeout_cnt   = 0;
    cycle_cnt     = 0;
    load_references();
    build_table();
    cycle_limit = 4 * tbl_len + 200;
    repeat (2) @(posedge hb_clk);
    #0.5;
    rst_sync = 1'b0;
    for (int k = 0; k < tbl_len; k++) begin
      run_op(tbl[k]);
    end
    finish_run();
  end

endmodule

// File: flist.f
source/xt_bus_pkg.sv
source/str_rom.sv
source/boot_rom.sv
source/user_imem.sv
source/hb_decoder.sv
source/harvard_bootloader.sv
source/hb_soc_top.sv
tests/tb_hb_soc_top.sv
